// ==== rtl/cacheCtrl.sv ====
`default_nettype none

module cacheCtrl (
    input  logic                                 clk,
    input  logic                                 rstN,
    input  logic                                 req,
    input  cachePkg::memOp_e                     op,
    input  logic [cachePkg::DataWidth-1:0]       addr,
    input  logic [cachePkg::DataWidth-1:0]       wdata,
    input  logic                                 anyHit,
    input  logic [cachePkg::WayIdxWidth-1:0]     hitWay,
    output logic [cachePkg::SetWidth-1:0]        setIdx,
    output logic [cachePkg::TagWidth-1:0]        tagOut,
    output logic [cachePkg::WordSelWidth-1:0]    wordIdx,
    output logic [cachePkg::NumWays-1:0]         fillWe,
    output logic [cachePkg::DataWidth-1:0]       fillData,
    output logic [cachePkg::NumWays-1:0]         storeWe,
    output logic [cachePkg::ByteLanes-1:0]       byteEn,
    output logic [cachePkg::DataWidth-1:0]       storeData,
    output logic [cachePkg::NumWays-1:0]         validSet,
    output logic [cachePkg::MemAddrWidth-1:0]    memAddr,
    output logic                                 memWe,
    output logic                                 memRe,
    output logic [cachePkg::ByteLanes-1:0]       memByteEn,
    output logic [cachePkg::DataWidth-1:0]       memWdata,
    input  logic [cachePkg::DataWidth-1:0]       memRdata,
    output logic [cachePkg::ByteOffset-1:0]      byteSel,
    output logic                                 loadByte,
    output logic                                 isLoad,
    output logic                                 done,
    output logic                                 hit,
    output logic                                 busy
);
    import cachePkg::*;

    cacheState_e              state;
    logic [NumSets-1:0]       lru;          // victim way per set
    logic [WordSelWidth:0]    cnt;          // fill step, 0..4
    logic [WayIdxWidth-1:0]   victimQ;

    logic [TagWidth-1:0]      tagQ;
    logic [SetWidth-1:0]      setQ;
    logic [WordSelWidth-1:0]  wordQ;
    logic [ByteOffset-1:0]    byteQ;
    logic                     lbuQ;

    logic [TagWidth-1:0]      reqTag;
    logic [SetWidth-1:0]      reqSet;
    logic [WordSelWidth-1:0]  reqWord;
    logic [ByteOffset-1:0]    reqByte;
    logic                     accept;
    logic                     isStore;
    logic                     storeReq;
    logic                     fillRet;
    logic                     lastFill;
    logic [WordSelWidth-1:0]  fillWord;
    logic [WordSelWidth-1:0]  issueWord;

    assign reqTag  = addr[DataWidth-1 -: TagWidth];
    assign reqSet  = addr[ByteOffset+WordSelWidth +: SetWidth];
    assign reqWord = addr[ByteOffset +: WordSelWidth];
    assign reqByte = addr[ByteOffset-1:0];

    assign accept   = (state != stFill);    // finish cycle takes requests too
    assign busy     = (state == stFill);
    assign isStore  = (op == opSw) || (op == opSb);
    assign storeReq = accept && req && isStore;

    // requested word is fetched last, so it lands in the finish lookup
    assign fillRet   = busy && (cnt != '0);
    assign lastFill  = busy && cnt[WordSelWidth];
    assign fillWord  = wordQ + cnt[WordSelWidth-1:0];
    assign issueWord = fillWord + 1'b1;

    assign setIdx   = accept ? reqSet  : setQ;
    assign tagOut   = accept ? reqTag  : tagQ;
    assign wordIdx  = accept ? reqWord : fillWord;
    assign byteSel  = accept ? reqByte : byteQ;
    assign loadByte = accept ? (op == opLbu) : lbuQ;
    assign isLoad   = accept ? (req && !isStore) : 1'b1;

    // byte lanes for sb
    always_comb begin
        byteEn    = '1;
        storeData = wdata;
        if (op == opSb) begin
            byteEn          = '0;
            byteEn[reqByte] = 1'b1;
            storeData       = {ByteLanes{wdata[7:0]}};
        end
    end

    always_comb begin
        for (int w = 0; w < NumWays; w++) begin
            storeWe[w]  = storeReq && anyHit && (hitWay == WayIdxWidth'(w));
            fillWe[w]   = fillRet && (victimQ == WayIdxWidth'(w));
            validSet[w] = lastFill && (victimQ == WayIdxWidth'(w));
        end
    end

    assign fillData  = memRdata;
    assign memWe     = storeReq;            // write-through, no allocate
    assign memRe     = busy && !cnt[WordSelWidth];
    assign memByteEn = byteEn;
    assign memWdata  = storeData;
    assign memAddr   = busy ? {tagQ[MemTagWidth-1:0], setQ, issueWord}
                            : addr[ByteOffset +: MemAddrWidth];

    always_ff @(posedge clk) begin
        if (accept && req) begin
            tagQ  <= reqTag;
            setQ  <= reqSet;
            wordQ <= reqWord;
            byteQ <= reqByte;
            lbuQ  <= (op == opLbu);
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state   <= stIdle;
            lru     <= '0;
            cnt     <= '0;
            victimQ <= '0;
            done    <= 1'b0;
            hit     <= 1'b0;
        end else begin
            done <= 1'b0;
            hit  <= 1'b0;
            case (state)
                stIdle, stFinish: begin
                    state <= stIdle;
                    if (req) begin
                        if (isStore || anyHit) begin
                            done <= 1'b1;
                            hit  <= anyHit;
                            if (anyHit) begin
                                lru[reqSet] <= ~hitWay;
                            end
                        end else begin
                            state   <= stFill;     // load miss
                            victimQ <= lru[reqSet];
                            cnt     <= '0;
                        end
                    end
                end
                stFill: begin
                    cnt <= cnt + 1'b1;
                    if (lastFill) begin
                        state     <= stFinish;
                        done      <= 1'b1;
                        lru[setQ] <= ~victimQ;
                        cnt       <= '0;
                    end
                end
                default: state <= stIdle;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== rtl/cachePkg.sv ====
`default_nettype none

package cachePkg;

    // address and data geometry
    localparam int DataWidth    = 32;
    localparam int TagWidth     = 25;
    localparam int SetWidth     = 3;
    localparam int NumSets      = 2 ** SetWidth;
    localparam int WordSelWidth = 2;
    localparam int WordsPerLine = 2 ** WordSelWidth;
    localparam int ByteOffset   = 2;
    localparam int ByteLanes    = DataWidth / 8;

    localparam int NumWays      = 2;
    localparam int WayIdxWidth  = $clog2(NumWays);

    // backing store decodes addr[9:2] only
    localparam int MemAddrWidth = 8;
    localparam int MemWords     = 2 ** MemAddrWidth;
    localparam int MemTagWidth  = MemAddrWidth - SetWidth - WordSelWidth; // low tag bits seen by memory

    typedef enum logic [1:0] {
        opLw,
        opLbu,
        opSw,
        opSb
    } memOp_e;

    typedef enum logic [1:0] {
        stIdle,
        stFill,
        stFinish
    } cacheState_e;

endpackage

`default_nettype wire

// ==== rtl/cacheWay.sv ====
`default_nettype none

module cacheWay (
    input  logic                                 clk,
    input  logic                                 rstN,
    input  logic [cachePkg::SetWidth-1:0]        setIdx,
    input  logic [cachePkg::TagWidth-1:0]        tagIn,
    input  logic [cachePkg::WordSelWidth-1:0]    wordIdx,
    input  logic                                 fillWe,
    input  logic [cachePkg::DataWidth-1:0]       fillData,
    input  logic                                 storeWe,
    input  logic [cachePkg::ByteLanes-1:0]       byteEn,
    input  logic [cachePkg::DataWidth-1:0]       storeData,
    input  logic                                 validSet,
    output logic                                 wayHit,
    output logic [cachePkg::DataWidth-1:0]       wordOut
);
    import cachePkg::*;

    logic [NumSets-1:0]   validQ;
    logic [TagWidth-1:0]  tagQ  [NumSets];
    logic [DataWidth-1:0] lineQ [NumSets][WordsPerLine];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            validQ <= '0;
        end else if (validSet) begin
            validQ[setIdx] <= 1'b1;
        end
    end

    // tag written together with valid at the last fill word
    always_ff @(posedge clk) begin
        if (validSet) begin
            tagQ[setIdx] <= tagIn;
        end
    end

    always_ff @(posedge clk) begin
        if (fillWe) begin
            lineQ[setIdx][wordIdx] <= fillData;
        end else if (storeWe) begin
            for (int b = 0; b < ByteLanes; b++) begin
                if (byteEn[b]) begin
                    lineQ[setIdx][wordIdx][8*b +: 8] <= storeData[8*b +: 8];
                end
            end
        end
    end

    // a set being validated this cycle counts as a hit, same as the data bypass below
    assign wayHit  = (validQ[setIdx] && (tagQ[setIdx] == tagIn)) || validSet;
    assign wordOut = fillWe ? fillData : lineQ[setIdx][wordIdx]; // fill bypass

endmodule

`default_nettype wire

// ==== rtl/dataCache.sv ====
`default_nettype none

module dataCache (
    input  logic                                 clk,
    input  logic                                 rstN,
    input  logic                                 req,
    input  cachePkg::memOp_e                     op,
    input  logic [cachePkg::DataWidth-1:0]       addr,
    input  logic [cachePkg::DataWidth-1:0]       wdata,
    output logic [cachePkg::DataWidth-1:0]       rdata,
    output logic                                 done,
    output logic                                 hit,
    output logic                                 busy
);
    import cachePkg::*;

    logic [SetWidth-1:0]      setIdx;
    logic [TagWidth-1:0]      tagOut;
    logic [WordSelWidth-1:0]  wordIdx;
    logic [NumWays-1:0]       fillWe;
    logic [DataWidth-1:0]     fillData;
    logic [NumWays-1:0]       storeWe;
    logic [ByteLanes-1:0]     byteEn;
    logic [DataWidth-1:0]     storeData;
    logic [NumWays-1:0]       validSet;

    logic [NumWays-1:0]       wayHit;
    logic [DataWidth-1:0]     wordOut [NumWays];
    logic                     anyHit;
    logic [WayIdxWidth-1:0]   hitWay;
    logic [ByteOffset-1:0]    byteSel;
    logic                     loadByte;
    logic                     isLoad;

    logic [MemAddrWidth-1:0]  memAddr;
    logic                     memWe;
    logic                     memRe;
    logic [ByteLanes-1:0]     memByteEn;
    logic [DataWidth-1:0]     memWdata;
    logic [DataWidth-1:0]     memRdata;

    cacheCtrl ctrl (
        .clk       (clk),
        .rstN      (rstN),
        .req       (req),
        .op        (op),
        .addr      (addr),
        .wdata     (wdata),
        .anyHit    (anyHit),
        .hitWay    (hitWay),
        .setIdx    (setIdx),
        .tagOut    (tagOut),
        .wordIdx   (wordIdx),
        .fillWe    (fillWe),
        .fillData  (fillData),
        .storeWe   (storeWe),
        .byteEn    (byteEn),
        .storeData (storeData),
        .validSet  (validSet),
        .memAddr   (memAddr),
        .memWe     (memWe),
        .memRe     (memRe),
        .memByteEn (memByteEn),
        .memWdata  (memWdata),
        .memRdata  (memRdata),
        .byteSel   (byteSel),
        .loadByte  (loadByte),
        .isLoad    (isLoad),
        .done      (done),
        .hit       (hit),
        .busy      (busy)
    );

    for (genvar w = 0; w < NumWays; w++) begin : ways
        cacheWay way (
            .clk       (clk),
            .rstN      (rstN),
            .setIdx    (setIdx),
            .tagIn     (tagOut),
            .wordIdx   (wordIdx),
            .fillWe    (fillWe[w]),
            .fillData  (fillData),
            .storeWe   (storeWe[w]),
            .byteEn    (byteEn),
            .storeData (storeData),
            .validSet  (validSet[w]),
            .wayHit    (wayHit[w]),
            .wordOut   (wordOut[w])
        );
    end

    hitMerge merge (
        .clk      (clk),
        .rstN     (rstN),
        .wayHit   (wayHit),
        .wordOut  (wordOut),
        .byteSel  (byteSel),
        .loadByte (loadByte),
        .isLoad   (isLoad),
        .anyHit   (anyHit),
        .hitWay   (hitWay),
        .rdata    (rdata)
    );

    dataMemory mem (
        .clk       (clk),
        .memAddr   (memAddr),
        .memWe     (memWe),
        .memRe     (memRe),
        .memByteEn (memByteEn),
        .memWdata  (memWdata),
        .memRdata  (memRdata)
    );

endmodule

`default_nettype wire

// ==== rtl/dataMemory.sv ====
`default_nettype none

module dataMemory (
    input  logic                                 clk,
    input  logic [cachePkg::MemAddrWidth-1:0]    memAddr,
    input  logic                                 memWe,
    input  logic                                 memRe,
    input  logic [cachePkg::ByteLanes-1:0]       memByteEn,
    input  logic [cachePkg::DataWidth-1:0]       memWdata,
    output logic [cachePkg::DataWidth-1:0]       memRdata
);
    import cachePkg::*;

    logic [DataWidth-1:0] mem [MemWords];

    // byte-lane writes
    always_ff @(posedge clk) begin
        if (memWe) begin
            for (int b = 0; b < ByteLanes; b++) begin
                if (memByteEn[b]) begin
                    mem[memAddr][8*b +: 8] <= memWdata[8*b +: 8];
                end
            end
        end
    end

    // data one cycle after memRe, held otherwise
    always_ff @(posedge clk) begin
        if (memRe) begin
            memRdata <= mem[memAddr];
        end
    end

endmodule

`default_nettype wire

// ==== rtl/hitMerge.sv ====
`default_nettype none

module hitMerge (
    input  logic                                 clk,
    input  logic                                 rstN,
    input  logic [cachePkg::NumWays-1:0]         wayHit,
    input  logic [cachePkg::DataWidth-1:0]       wordOut [cachePkg::NumWays],
    input  logic [cachePkg::ByteOffset-1:0]      byteSel,
    input  logic                                 loadByte,
    input  logic                                 isLoad,
    output logic                                 anyHit,
    output logic [cachePkg::WayIdxWidth-1:0]     hitWay,
    output logic [cachePkg::DataWidth-1:0]       rdata
);
    import cachePkg::*;

    logic [DataWidth-1:0] hitWord;
    logic [7:0]           hitByte;
    logic [DataWidth-1:0] loadData;

    // lowest hitting way wins, only one can match anyway
    always_comb begin
        hitWay = '0;
        for (int w = NumWays - 1; w >= 0; w--) begin
            if (wayHit[w]) begin
                hitWay = WayIdxWidth'(w);
            end
        end
    end

    assign anyHit   = |wayHit;
    assign hitWord  = wordOut[hitWay];
    assign hitByte  = hitWord[{byteSel, 3'b000} +: 8];
    assign loadData = loadByte ? {{(DataWidth-8){1'b0}}, hitByte} : hitWord; // lbu zero-extends

    // stores and misses return zero
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            rdata <= '0;
        end else begin
            rdata <= (isLoad && anyHit) ? loadData : '0;
        end
    end

endmodule

`default_nettype wire

// ==== src.f ====
rtl/cachePkg.sv
rtl/cacheWay.sv
rtl/cacheCtrl.sv
rtl/hitMerge.sv
rtl/dataMemory.sv
rtl/dataCache.sv
test/tbDataCache.sv

// ==== test/tbDataCache.sv ====
`default_nettype none

module tbDataCache;
    import cachePkg::*;

    localparam int TimeoutCycles = 20;
    localparam int RandomOps     = 3000;

    logic                 clk;
    logic                 rstN;
    logic                 req;
    memOp_e               op;
    logic [DataWidth-1:0] addr;
    logic [DataWidth-1:0] wdata;
    logic [DataWidth-1:0] rdata;
    logic                 done;
    logic                 hit;
    logic                 busy;

    // reference model of memory and tag state
    logic [DataWidth-1:0] refMem   [MemWords];
    logic [TagWidth-1:0]  refTag   [NumSets][NumWays];
    logic [NumWays-1:0]   refValid [NumSets];
    logic [NumSets-1:0]   refLru;

    integer seed;
    int     dataErrors;
    int     hitErrors;
    int     busyErrors;
    int     otherErrors;

    dataCache dut (
        .clk   (clk),
        .rstN  (rstN),
        .req   (req),
        .op    (op),
        .addr  (addr),
        .wdata (wdata),
        .rdata (rdata),
        .done  (done),
        .hit   (hit),
        .busy  (busy)
    );

    always #2 clk = ~clk;

    function automatic logic [DataWidth-1:0] makeAddr(input int tagBits, input int setBits,
                                                      input int wordBits, input int byteBits);
        return (tagBits << (SetWidth + WordSelWidth + ByteOffset))
             | (setBits << (WordSelWidth + ByteOffset))
             | (wordBits << ByteOffset)
             | byteBits;
    endfunction

    task automatic checkData(input logic [DataWidth-1:0] actual,
                             input logic [DataWidth-1:0] expected,
                             input logic [DataWidth-1:0] atAddr);
        if (actual !== expected) begin
            dataErrors++;
            $display("Mismatch rdata: got %08h, expected %08h (addr %08h)",
                     actual, expected, atAddr);
        end
    endtask

    task automatic checkHit(input logic actual, input logic expected,
                            input logic [DataWidth-1:0] atAddr);
        if (actual !== expected) begin
            hitErrors++;
            $display("Mismatch hit: got %0h, expected %0h (addr %08h)", actual, expected, atAddr);
        end
    endtask

    task automatic checkBusy(input logic actual, input logic expected,
                             input logic [DataWidth-1:0] atAddr);
        if (actual !== expected) begin
            busyErrors++;
            $display("Mismatch busy: got %0h, expected %0h (addr %08h)", actual, expected, atAddr);
        end
    endtask

    // predicts one access and updates the model
    task automatic predictAccess(
        input  memOp_e               opIn,
        input  logic [DataWidth-1:0] addrIn,
        input  logic [DataWidth-1:0] wdataIn,
        output logic [DataWidth-1:0] expData,
        output logic                 expHit
    );
        logic [TagWidth-1:0]     t;
        logic [SetWidth-1:0]     s;
        logic [MemAddrWidth-1:0] m;
        logic [ByteOffset-1:0]   b;
        logic [DataWidth-1:0]    word;
        logic                    victim;
        int                      hw;
        t  = addrIn[DataWidth-1 -: TagWidth];
        s  = addrIn[ByteOffset+WordSelWidth +: SetWidth];
        m  = addrIn[ByteOffset +: MemAddrWidth];
        b  = addrIn[ByteOffset-1:0];
        hw = -1;
        for (int w = 0; w < NumWays; w++) begin
            if (refValid[s][w] && refTag[s][w] == t) begin
                hw = w;
            end
        end
        expHit  = (hw >= 0);
        expData = '0;
        word    = refMem[m];
        case (opIn)
            opLw: expData = word;
            opLbu: expData = {{(DataWidth-8){1'b0}}, word[8*b +: 8]};
            opSw: refMem[m] = wdataIn;      // write-through
            opSb: begin
                word[8*b +: 8] = wdataIn[7:0];
                refMem[m]      = word;
            end
            default: expData = '0;
        endcase
        if (expHit) begin
            refLru[s] = (hw == 0);          // other way becomes victim
        end else if (opIn == opLw || opIn == opLbu) begin
            victim              = refLru[s];
            refTag[s][victim]   = t;
            refValid[s][victim] = 1'b1;
            refLru[s]           = ~victim;
        end
    endtask

    task automatic waitIdle();
        int waitCycles;
        waitCycles = 0;
        while (busy && waitCycles < TimeoutCycles) begin
            @(posedge clk);
            #1;
            waitCycles++;
        end
        if (busy) begin
            otherErrors++;
            $display("busy stayed high for %0d cycles", TimeoutCycles);
        end
    endtask

    task automatic runAccess(input memOp_e opIn, input logic [DataWidth-1:0] addrIn,
                             input logic [DataWidth-1:0] wdataIn);
        logic [DataWidth-1:0] expData;
        logic                 expHit;
        logic                 expBusy;
        int                   waitCycles;
        waitIdle();
        predictAccess(opIn, addrIn, wdataIn, expData, expHit);
        expBusy = !expHit && (opIn == opLw || opIn == opLbu);
        req   = 1'b1;
        op    = opIn;
        addr  = addrIn;
        wdata = wdataIn;
        @(posedge clk);
        #1;
        req        = 1'b0;
        checkBusy(busy, expBusy, addrIn);   // only a load miss refills
        waitCycles = 0;
        while (!done && waitCycles < TimeoutCycles) begin
            @(posedge clk);
            #1;
            waitCycles++;
        end
        if (!done) begin
            otherErrors++;
            $display("no done pulse within %0d cycles for op %0d at addr %08h",
                     TimeoutCycles, opIn, addrIn);
        end else begin
            checkData(rdata, expData, addrIn);
            checkHit(hit, expHit, addrIn);
            if (expBusy) begin
                checkBusy(busy, 1'b0, addrIn);  // falls with done
            end
        end
    endtask

    initial begin
        logic [DataWidth-1:0] a;
        logic [DataWidth-1:0] r;
        clk         = 1'b0;
        rstN        = 1'b0;
        req         = 1'b0;
        op          = opLw;
        addr        = '0;
        wdata       = '0;
        seed        = 32'h21a81bc7;
        dataErrors  = 0;
        hitErrors   = 0;
        busyErrors  = 0;
        otherErrors = 0;
        refLru      = '0;
        for (int s = 0; s < NumSets; s++) begin
            refValid[s] = '0;
        end

        repeat (8) @(posedge clk);
        #1;
        rstN = 1'b1;
        if (done !== 1'b0 || busy !== 1'b0 || hit !== 1'b0) begin
            otherErrors++;
            $display("done, busy or hit not low after reset");
        end

        // store sweep over every memory word while nothing is cached
        for (int i = 0; i < MemWords; i++) begin
            runAccess(opSw, i << ByteOffset, $random(seed));
        end

        a = makeAddr(2, 1, 3, 0);
        runAccess(opSw, a, 32'hcafe_f00d);
        runAccess(opLw, a, '0);             // line miss
        runAccess(opLw, a, '0);
        runAccess(opLw, makeAddr(2, 1, 0, 0), '0);

        // each byte load misses at offset k and hits at the mirrored offset
        for (int k = 0; k < 4; k++) begin
            runAccess(opLbu, makeAddr(6, 4 + k, k, k), '0);
            runAccess(opLbu, makeAddr(6, 4 + k, 3 - k, 3 - k), '0);
        end

        // store hits merge into the cached line
        runAccess(opSb, makeAddr(6, 4, 1, 1), $random(seed));
        runAccess(opSb, makeAddr(6, 4, 1, 3), $random(seed));
        runAccess(opSw, makeAddr(6, 5, 2, 0), $random(seed));
        runAccess(opLw, makeAddr(6, 4, 1, 0), '0);
        runAccess(opLbu, makeAddr(6, 4, 1, 3), '0);
        runAccess(opLw, makeAddr(6, 5, 2, 0), '0);

        // three tags fighting over set 3
        runAccess(opLw, makeAddr(1, 3, 0, 0), '0);
        runAccess(opLw, makeAddr(2, 3, 1, 0), '0);
        runAccess(opLw, makeAddr(1, 3, 2, 0), '0);
        runAccess(opLw, makeAddr(3, 3, 3, 0), '0);    // tag 2 goes
        runAccess(opSw, makeAddr(2, 3, 1, 0), $random(seed));
        runAccess(opLw, makeAddr(2, 3, 1, 0), '0);
        runAccess(opLw, makeAddr(1, 3, 0, 0), '0);
        runAccess(opLw, makeAddr(3, 3, 3, 0), '0);

        for (int n = 0; n < RandomOps; n++) begin
            r = $random(seed);
            a = $random(seed);
            a = a & 32'h0000_03ff;          // memory aliases above bit 9
            if (r[4:2] == 3'd0) begin
                @(posedge clk);
                #1;
            end
            runAccess(memOp_e'(r[1:0]), a, $random(seed));
        end

        $display("errors: data %0d, hit %0d, busy %0d, other %0d",
                 dataErrors, hitErrors, busyErrors, otherErrors);
        if (dataErrors + hitErrors + busyErrors + otherErrors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
